//--- logic/hyper_rd_pkg.sv
// Shared widths and enums for the HyperBus read-data path.
// Imported by every RTL module of the read path and by the testbench.

package hyper_rd_pkg;

  // AXI data word and byte offset within it.
  localparam int AXI_DW    = 64;
  localparam int AXI_OFS_W = 3;

  // two 16-bit PHYs side by side.
  localparam int PHY_DW    = 32;

  // burst length field and byte counters.
  localparam int BURST_W   = 8;

  localparam int REG_DW    = 16;

  // AXI beat size, encoded as log2 of the byte count.
  typedef enum logic [1:0] {
    SIZE_1B,
    SIZE_2B,
    SIZE_4B,
    SIZE_8B
  } xfer_size_e;

  typedef enum logic [1:0] {
    IDLE,
    WAIT_DATA,
    SAMPLE,
    EMIT
  } split_state_e;

  typedef enum logic {
    REG_CMD,
    REG_STATUS
  } reg_addr_e;

endpackage

//--- logic/hyper_rd_cfg.sv
// Command and status registers of the read path.
// A REG_CMD write launches a transaction; REG_STATUS shows busy and sticky errors.

`timescale 1ns/100ps

module hyper_rd_cfg
  import hyper_rd_pkg::*;
(
  input  logic                 clk_i,
  input  logic                 rst_ni,
  input  logic                 reg_we_i,
  input  reg_addr_e            reg_addr_i,
  input  logic [REG_DW-1:0]    reg_wdata_i,
  output logic [REG_DW-1:0]    reg_rdata_o,
  input  logic                 busy_i,
  input  logic                 phy_err_i,
  input  logic                 len_err_i,
  output logic                 launch_o,
  output logic [AXI_OFS_W-1:0] start_ofs_o,
  output xfer_size_e           size_o,
  output logic [BURST_W-1:0]   burst_len_o
);

  logic launch_q;
  logic phy_err_q;
  logic len_err_q;
  logic cmd_accept;

  // a launch already in flight counts as busy until the splitter raises busy_i.
  assign cmd_accept = reg_we_i && (reg_addr_i == REG_CMD) && !busy_i && !launch_q;

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      launch_q    <= 1'b0;
      start_ofs_o <= '0;
      size_o      <= SIZE_1B;
      burst_len_o <= '0;
      phy_err_q   <= 1'b0;
      len_err_q   <= 1'b0;
    end else begin
      launch_q <= cmd_accept;
      if (cmd_accept) begin
        start_ofs_o <= reg_wdata_i[2:0];
        size_o      <= xfer_size_e'(reg_wdata_i[5:4]);
        burst_len_o <= reg_wdata_i[15:8];
      end
      // a new error in the same cycle as the clear wins.
      if (reg_we_i && reg_addr_i == REG_STATUS) begin
        phy_err_q <= 1'b0;
        len_err_q <= 1'b0;
      end
      if (phy_err_i) phy_err_q <= 1'b1;
      if (len_err_i) len_err_q <= 1'b1;
    end
  end

  assign launch_o = launch_q;

  always_comb begin
    if (reg_addr_i == REG_CMD) begin
      reg_rdata_o = {burst_len_o, 2'b00, size_o, 1'b0, start_ofs_o};
    end else begin
      reg_rdata_o = {13'b0, len_err_q, phy_err_q, busy_i | launch_q};
    end
  end

  // the splitter must be back in idle before a new command goes out.
  a_launch_idle: assert property (@(posedge clk_i) disable iff (!rst_ni)
    launch_o |-> !busy_i);

endmodule

//--- logic/hyper_rd_splitter.sv
// Gathers 32-bit PHY beats into a 64-bit buffer and emits size-aligned AXI read beats.
// Launched by hyper_rd_cfg; its beats go through hyper_rd_outq to the AXI port.

`timescale 1ns/100ps

module hyper_rd_splitter
  import hyper_rd_pkg::*;
(
  input  logic                 clk_i,
  input  logic                 rst_ni,
  input  logic                 launch_i,
  input  logic [AXI_OFS_W-1:0] start_ofs_i,
  input  xfer_size_e           size_i,
  input  logic [BURST_W-1:0]   burst_len_i,
  input  logic                 phy_valid_i,
  input  logic [PHY_DW-1:0]    phy_data_i,
  input  logic                 phy_last_i,
  input  logic                 phy_err_i,
  output logic                 phy_ready_o,
  output logic                 beat_valid_o,
  output logic [AXI_DW-1:0]    beat_data_o,
  output logic                 beat_last_o,
  output logic                 beat_err_o,
  input  logic                 beat_ready_i,
  output logic                 busy_o,
  output logic                 phy_err_o,
  output logic                 len_err_o
);

  split_state_e state_q, state_d;
  xfer_size_e size_q;

  logic [BURST_W-1:0] axi_addr_q;
  logic [BURST_W-1:0] phy_cnt_q;
  logic [BURST_W-1:0] last_addr_q;
  logic [AXI_DW-1:0]  buf_q;
  logic               err_q;

  logic [BURST_W-1:0] beat_bytes;
  logic [BURST_W-1:0] axi_base;
  logic [BURST_W-1:0] next_axi_addr;
  logic [BURST_W-1:0] next_end;
  logic [BURST_W-1:0] phy_end;
  logic [BURST_W-1:0] start_bytes;
  logic [BURST_W-1:0] start_base;
  logic               phy_fire;
  logic               beat_fire;
  logic               final_beat;

  assign beat_bytes    = BURST_W'(1) << size_q;
  assign axi_base      = axi_addr_q & ~(beat_bytes - 1'b1);
  // next_axi_addr is also the end of the beat now being built.
  assign next_axi_addr = axi_base + beat_bytes;
  assign next_end      = next_axi_addr + beat_bytes;
  assign phy_end       = phy_cnt_q + BURST_W'(PHY_DW / 8);

  assign start_bytes = BURST_W'(1) << size_i;
  assign start_base  = BURST_W'(start_ofs_i) & ~(start_bytes - 1'b1);

  assign phy_fire   = phy_valid_i & phy_ready_o;
  assign beat_fire  = beat_valid_o & beat_ready_i;
  // the final PHY beat holds byte last_addr - 1.
  assign final_beat = phy_end >= last_addr_q;

  always_comb begin
    state_d      = state_q;
    phy_ready_o  = 1'b0;
    beat_valid_o = 1'b0;
    case (state_q)
      IDLE: begin
        if (launch_i) state_d = WAIT_DATA;
      end
      WAIT_DATA: begin
        if (phy_valid_i) state_d = SAMPLE;
      end
      SAMPLE: begin
        phy_ready_o = 1'b1;
        if (phy_valid_i && phy_end >= next_axi_addr) state_d = EMIT;
      end
      EMIT: begin
        beat_valid_o = 1'b1;
        if (beat_ready_i) begin
          if (beat_last_o) begin
            state_d = IDLE;
          end else if (next_end > phy_cnt_q) begin
            // the following beat needs bytes not yet received.
            state_d = WAIT_DATA;
          end
        end
      end
    endcase
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      state_q     <= IDLE;
      size_q      <= SIZE_1B;
      axi_addr_q  <= '0;
      phy_cnt_q   <= '0;
      last_addr_q <= '0;
      err_q       <= 1'b0;
    end else begin
      state_q <= state_d;
      if (launch_i && state_q == IDLE) begin
        size_q      <= size_i;
        axi_addr_q  <= BURST_W'(start_ofs_i);
        phy_cnt_q   <= BURST_W'({start_ofs_i[AXI_OFS_W-1:2], 2'b00});
        last_addr_q <= start_base + (burst_len_i << size_i);
        err_q       <= 1'b0;
      end else begin
        if (phy_fire) begin
          phy_cnt_q <= phy_end;
          if (phy_err_i) err_q <= 1'b1;
        end
        if (beat_fire) axi_addr_q <= next_axi_addr;
      end
    end
  end

  // bit 2 of the PHY counter picks the buffer half.
  always_ff @(posedge clk_i) begin
    if (phy_fire) buf_q[phy_cnt_q[2]*PHY_DW +: PHY_DW] <= phy_data_i;
  end

  assign beat_data_o = buf_q;
  assign beat_last_o = beat_valid_o && (next_axi_addr == last_addr_q);
  assign beat_err_o  = err_q;
  assign busy_o      = (state_q != IDLE);
  assign phy_err_o   = phy_fire & phy_err_i;
  assign len_err_o   = phy_fire & (phy_last_i != final_beat);

  // a PHY beat is only taken while the beat being built still lacks bytes.
  a_phy_needed: assert property (@(posedge clk_i) disable iff (!rst_ni)
    phy_fire |-> (phy_cnt_q < next_axi_addr));

  // the closing beat may only leave once the PHY stream covers the whole burst.
  a_last_covered: assert property (@(posedge clk_i) disable iff (!rst_ni)
    (beat_fire && beat_last_o) |-> (phy_cnt_q >= last_addr_q));

endmodule

//--- logic/hyper_rd_outq.sv
// Two-entry registered queue between the splitter and the AXI read data port.
// Holds its head entry stable until the AXI side takes it.

`timescale 1ns/100ps

module hyper_rd_outq
  import hyper_rd_pkg::*;
(
  input  logic              clk_i,
  input  logic              rst_ni,
  input  logic              in_valid_i,
  input  logic [AXI_DW-1:0] in_data_i,
  input  logic              in_last_i,
  input  logic              in_err_i,
  output logic              in_ready_o,
  output logic              out_valid_o,
  output logic [AXI_DW-1:0] out_data_o,
  output logic              out_last_o,
  output logic              out_err_o,
  input  logic              out_ready_i
);

  logic [AXI_DW-1:0] data_q [2];
  logic [1:0]        last_q;
  logic [1:0]        err_q;
  logic              wr_ptr_q;
  logic              rd_ptr_q;
  logic [1:0]        count_q;
  logic              push;
  logic              pop;

  assign in_ready_o  = (count_q != 2'd2);
  assign out_valid_o = (count_q != 2'd0);
  assign push        = in_valid_i & in_ready_o;
  assign pop         = out_valid_o & out_ready_i;

  always_ff @(posedge clk_i) begin
    if (push) begin
      data_q[wr_ptr_q] <= in_data_i;
      last_q[wr_ptr_q] <= in_last_i;
      err_q[wr_ptr_q]  <= in_err_i;
    end
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      wr_ptr_q <= 1'b0;
      rd_ptr_q <= 1'b0;
      count_q  <= 2'd0;
    end else begin
      if (push) wr_ptr_q <= ~wr_ptr_q;
      if (pop) rd_ptr_q <= ~rd_ptr_q;
      case ({push, pop})
        2'b10:   count_q <= count_q + 2'd1;
        2'b01:   count_q <= count_q - 2'd1;
        default: count_q <= count_q;
      endcase
    end
  end

  assign out_data_o = data_q[rd_ptr_q];
  assign out_last_o = last_q[rd_ptr_q];
  assign out_err_o  = err_q[rd_ptr_q];

  // the count stays within two and agrees with the pointer distance.
  a_count_ptrs: assert property (@(posedge clk_i) disable iff (!rst_ni)
    (count_q <= 2'd2) && ((count_q == 2'd1) == (wr_ptr_q != rd_ptr_q)));

endmodule

//--- logic/hyper_rd_top.sv
// Top of the HyperBus read-data path.
// Register block, splitter and output queue wired together.

`timescale 1ns/100ps

module hyper_rd_top
  import hyper_rd_pkg::*;
(
  input  logic              clk_i,
  input  logic              rst_ni,
  input  logic              reg_we_i,
  input  reg_addr_e         reg_addr_i,
  input  logic [REG_DW-1:0] reg_wdata_i,
  output logic [REG_DW-1:0] reg_rdata_o,
  input  logic              phy_valid_i,
  input  logic [PHY_DW-1:0] phy_data_i,
  input  logic              phy_last_i,
  input  logic              phy_err_i,
  output logic              phy_ready_o,
  output logic              axi_valid_o,
  output logic [AXI_DW-1:0] axi_data_o,
  output logic              axi_last_o,
  output logic              axi_err_o,
  input  logic              axi_ready_i
);

  logic                 launch;
  logic [AXI_OFS_W-1:0] start_ofs;
  xfer_size_e           size;
  logic [BURST_W-1:0]   burst_len;
  logic                 busy;
  logic                 phy_err;
  logic                 len_err;
  logic                 beat_valid;
  logic [AXI_DW-1:0]    beat_data;
  logic                 beat_last;
  logic                 beat_err;
  logic                 q_ready;

  hyper_rd_cfg cfg_inst (
    .clk_i       (clk_i),
    .rst_ni      (rst_ni),
    .reg_we_i    (reg_we_i),
    .reg_addr_i  (reg_addr_i),
    .reg_wdata_i (reg_wdata_i),
    .reg_rdata_o (reg_rdata_o),
    .busy_i      (busy),
    .phy_err_i   (phy_err),
    .len_err_i   (len_err),
    .launch_o    (launch),
    .start_ofs_o (start_ofs),
    .size_o      (size),
    .burst_len_o (burst_len)
  );

  hyper_rd_splitter splitter_inst (
    .clk_i        (clk_i),
    .rst_ni       (rst_ni),
    .launch_i     (launch),
    .start_ofs_i  (start_ofs),
    .size_i       (size),
    .burst_len_i  (burst_len),
    .phy_valid_i  (phy_valid_i),
    .phy_data_i   (phy_data_i),
    .phy_last_i   (phy_last_i),
    .phy_err_i    (phy_err_i),
    .phy_ready_o  (phy_ready_o),
    .beat_valid_o (beat_valid),
    .beat_data_o  (beat_data),
    .beat_last_o  (beat_last),
    .beat_err_o   (beat_err),
    .beat_ready_i (q_ready),
    .busy_o       (busy),
    .phy_err_o    (phy_err),
    .len_err_o    (len_err)
  );

  hyper_rd_outq outq_inst (
    .clk_i       (clk_i),
    .rst_ni      (rst_ni),
    .in_valid_i  (beat_valid),
    .in_data_i   (beat_data),
    .in_last_i   (beat_last),
    .in_err_i    (beat_err),
    .in_ready_o  (q_ready),
    .out_valid_o (axi_valid_o),
    .out_data_o  (axi_data_o),
    .out_last_o  (axi_last_o),
    .out_err_o   (axi_err_o),
    .out_ready_i (axi_ready_i)
  );

endmodule

//--- tb/tb_clkgen.sv
// Clock and reset for the read-path testbench.
// 20 ns clock; reset held low for the first 10 cycles.

`timescale 1ns/100ps

module tb_clkgen (
  output logic clk_o,
  output logic rst_no
);

  initial begin
    clk_o = 1'b0;
    forever #10 clk_o = ~clk_o;
  end

  // release away from the rising edge.
  initial begin
    rst_no = 1'b0;
    repeat (10) @(posedge clk_o);
    @(negedge clk_o);
    rst_no = 1'b1;
  end

endmodule

//--- tb/tb_hyper_rd.sv
// Randomized testbench for the HyperBus read-data path.
// Drives PHY beats and AXI stalls, and checks every AXI beat against a byte-stream model.

`timescale 1ns/100ps

module tb_hyper_rd
  import hyper_rd_pkg::*;
();

  logic              clk;
  logic              rst_n;
  logic              reg_we;
  reg_addr_e         reg_addr;
  logic [REG_DW-1:0] reg_wdata;
  logic [REG_DW-1:0] reg_rdata;
  logic              phy_valid;
  logic [PHY_DW-1:0] phy_data;
  logic              phy_last;
  logic              phy_err;
  logic              phy_ready;
  logic              axi_valid;
  logic [AXI_DW-1:0] axi_data;
  logic              axi_last;
  logic              axi_err;
  logic              axi_ready;

  integer     seed;
  int         mismatch_errs;
  int         timeout_errs;
  bit         abort;
  logic [7:0] stream [256];
  int         start_ofs, size_log, nbytes, blen;
  int         start_base, last_addr, stream_base, n_phy;
  int         err_beat, early_last;

  tb_clkgen clkgen_inst (.clk_o(clk), .rst_no(rst_n));

  hyper_rd_top hyper_rd_top_inst (
    .clk_i(clk), .rst_ni(rst_n),
    .reg_we_i(reg_we), .reg_addr_i(reg_addr), .reg_wdata_i(reg_wdata), .reg_rdata_o(reg_rdata),
    .phy_valid_i(phy_valid), .phy_data_i(phy_data), .phy_last_i(phy_last),
    .phy_err_i(phy_err), .phy_ready_o(phy_ready),
    .axi_valid_o(axi_valid), .axi_data_o(axi_data), .axi_last_o(axi_last),
    .axi_err_o(axi_err), .axi_ready_i(axi_ready)
  );

  function automatic int rand_below(int n);
    return int'($unsigned($random(seed)) % n);
  endfunction

  // beat i leaves once the PHY beats up to roundup4(end of beat i) are in.
  function automatic bit beat_err_expected(int i);
    int phy_needed;
    if (err_beat < 0) return 1'b0;
    phy_needed = (((start_base + (i + 1) * nbytes + 3) & ~3) - stream_base) / 4;
    return err_beat < phy_needed;
  endfunction

  task automatic check_value(string name, logic [AXI_DW-1:0] got, logic [AXI_DW-1:0] exp);
    assert (got === exp) else begin
      $display("FAIL %0t %s got %h expected %h", $time, name, got, exp);
      mismatch_errs++;
    end
  endtask

  task automatic give_up(string what);
    $display("%0t: timed out waiting for %s", $time, what);
    timeout_errs++;
    abort = 1'b1;
  endtask

  task automatic write_reg(reg_addr_e addr, logic [REG_DW-1:0] data);
    @(negedge clk);
    reg_we    = 1'b1;
    reg_addr  = addr;
    reg_wdata = data;
    @(negedge clk);
    reg_we = 1'b0;
  endtask

  task automatic read_status(output logic [2:0] st);
    @(negedge clk);
    reg_addr = REG_STATUS;
    #5;
    st = reg_rdata[2:0];
  endtask

  task automatic drive_phy();
    int  k;
    int  b;
    int  waited;
    bit  taken;
    for (k = 0; k < n_phy && !abort; k++) begin
      b      = stream_base + 4 * k;
      taken  = 1'b0;
      waited = 0;
      while (!taken && !abort) begin
        @(negedge clk);
        phy_valid = (rand_below(4) != 0);
        phy_data  = {stream[b+3], stream[b+2], stream[b+1], stream[b]};
        phy_last  = (k == early_last) || (early_last < 0 && k == n_phy - 1);
        phy_err   = (k == err_beat);
        #5;
        if (phy_valid && phy_ready) begin
          taken = 1'b1;
        end else begin
          waited++;
          assert (waited < 300) else give_up("phy_ready_o");
        end
      end
    end
    @(negedge clk);
    phy_valid = 1'b0;
    phy_last  = 1'b0;
    phy_err   = 1'b0;
  endtask

  task automatic check_beat(int i);
    int                addr;
    int                lane;
    logic [AXI_DW-1:0] mask;
    logic [AXI_DW-1:0] exp;
    addr = (i == 0) ? start_ofs : start_base + i * nbytes;
    mask = '0;
    exp  = '0;
    // lanes run from the beat address to the end of its size-aligned window.
    for (lane = addr % 8; lane < (start_base + i * nbytes) % 8 + nbytes; lane++) begin
      mask[lane*8 +: 8] = 8'hff;
      exp[lane*8 +: 8]  = stream[(addr & ~7) + lane];
    end
    check_value("axi_data_o", axi_data & mask, exp);
    check_value("axi_last_o", axi_last, i == blen - 1);
    check_value("axi_err_o", axi_err, beat_err_expected(i));
  endtask

  task automatic collect_axi();
    int                i;
    int                idle;
    bit                hold;
    logic [AXI_DW-1:0] held_data;
    logic              held_last;
    logic              held_err;
    i    = 0;
    idle = 0;
    hold = 1'b0;
    while (i < blen && !abort) begin
      @(negedge clk);
      axi_ready = (rand_below(3) != 0);
      #5;
      if (hold) begin
        check_value("axi_valid_o", axi_valid, 1'b1);
        check_value("axi_data_o", axi_data, held_data);
        check_value("axi_last_o", axi_last, held_last);
        check_value("axi_err_o", axi_err, held_err);
      end
      hold      = axi_valid && !axi_ready;
      held_data = axi_data;
      held_last = axi_last;
      held_err  = axi_err;
      if (axi_valid && axi_ready) begin
        check_beat(i);
        i++;
        idle = 0;
      end else begin
        idle++;
        assert (idle < 300) else give_up("an AXI beat");
      end
    end
    @(negedge clk);
    axi_ready = 1'b0;
  endtask

  // a command written while busy must not start a second burst.
  task automatic poke_while_busy();
    logic [2:0] st;
    repeat (rand_below(2)) @(negedge clk);
    reg_addr = REG_STATUS;
    #5;
    st = reg_rdata[2:0];
    check_value("reg_rdata_o[0]", st[0], 1'b1);
    if (st[0]) write_reg(REG_CMD, REG_DW'($random(seed)));
  endtask

  task automatic run_transaction();
    logic [2:0] st;
    int         a;
    int         waited;
    bit         do_poke;
    start_ofs   = rand_below(8);
    size_log    = rand_below(4);
    blen        = 1 + rand_below(12);
    nbytes      = 1 << size_log;
    start_base  = start_ofs & ~(nbytes - 1);
    last_addr   = start_base + blen * nbytes;
    stream_base = start_ofs & ~3;
    n_phy       = (((last_addr + 3) & ~3) - stream_base) / 4;
    err_beat    = (rand_below(4) == 0) ? rand_below(n_phy) : -1;
    early_last  = (n_phy > 1 && rand_below(6) == 0) ? rand_below(n_phy - 1) : -1;
    do_poke     = (rand_below(3) == 0);
    for (a = 0; a < 256; a++) begin
      stream[a] = 8'($random(seed));
    end
    write_reg(REG_CMD, {8'(blen), 2'b00, 2'(size_log), 1'b0, 3'(start_ofs)});
    fork
      drive_phy();
      collect_axi();
      if (do_poke) poke_while_busy();
    join
    waited = 0;
    st     = 3'b001;
    while (st[0] && !abort) begin
      read_status(st);
      waited++;
      assert (waited < 50) else give_up("busy to fall");
    end
    repeat (3) begin
      @(negedge clk);
      #5;
      check_value("axi_valid_o", axi_valid, 1'b0);
    end
    check_value("reg_rdata_o[1]", st[1], err_beat >= 0);
    check_value("reg_rdata_o[2]", st[2], early_last >= 0);
    write_reg(REG_STATUS, '0);
    read_status(st);
    check_value("reg_rdata_o", st, 3'b000);
  endtask

  initial begin
    logic [2:0] st;
    int         t;
    int         waited;
    seed          = 32'h71bf;
    mismatch_errs = 0;
    timeout_errs  = 0;
    abort         = 1'b0;
    reg_we        = 1'b0;
    reg_addr      = REG_CMD;
    reg_wdata     = '0;
    phy_valid     = 1'b0;
    phy_data      = '0;
    phy_last      = 1'b0;
    phy_err       = 1'b0;
    axi_ready     = 1'b0;
    waited        = 0;
    while (rst_n !== 1'b1 && !abort) begin
      @(negedge clk);
      waited++;
      assert (waited < 50) else give_up("reset release");
    end
    read_status(st);
    check_value("axi_valid_o", axi_valid, 1'b0);
    check_value("phy_ready_o", phy_ready, 1'b0);
    check_value("reg_rdata_o", st, 3'b000);
    for (t = 0; t < 200 && !abort; t++) begin
      run_transaction();
    end
    $display("errors: %0d mismatches, %0d timeouts", mismatch_errs, timeout_errs);
    if (mismatch_errs == 0 && timeout_errs == 0) begin
      $display("SIMULATION PASSED");
    end else begin
      $display("SIMULATION FAILED");
    end
    $finish;
  end

endmodule

//--- files.f
logic/hyper_rd_pkg.sv
logic/hyper_rd_cfg.sv
logic/hyper_rd_splitter.sv
logic/hyper_rd_outq.sv
logic/hyper_rd_top.sv
tb/tb_clkgen.sv
tb/tb_hyper_rd.sv

//--- run.sh
#!/bin/sh
# Builds the read-path testbench with Verilator and runs it.
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -Wno-fatal -f files.f \
  --top-module tb_hyper_rd -o sim_hyper_rd
if [ $? -ne 0 ]; then
  echo "verilator build failed"
  exit 1
fi

out=$(./obj_dir/sim_hyper_rd)
status=$?
echo "$out"
if [ $status -ne 0 ]; then
  echo "simulation exited with status $status"
  exit 1
fi

if echo "$out" | grep -q "SIMULATION PASSED"; then
  exit 0
fi
exit 1
